// File: compile.f
+incdir+common
common/srtDivPkg.sv
hw/srtDivCtrl.sv
hw/srtIterCounter.sv
hw/srtDatapath/srtQuotSel.sv
hw/srtDatapath/srtResidual.sv
hw/srtDatapath/srtOtfConvert.sv
hw/srtDivider.sv
testbench/srtDividerTb.sv

// File: Makefile
# Verilator build and run of the SRT divider testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = srtDividerTb
FILELIST  = compile.f
BUILD     = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// File: testbench/srtDividerTb.sv
////////////////////////////////////////
// Directed values scale with DIVLEN
// Random operands assume DIVLEN <= 32
////////////////////////////////////////
`timescale 1ns/1ps
`include "srtDivDefines.svh"

module srtDividerTb;
  import srtDivPkg::*;

  typedef struct {
    operand_t dividend;
    operand_t divisor;
    quot_t    quot;
    logic     inexact;
  } vector_t;

  localparam int tableLen  = 8;
  localparam int randCount = 200;
  // Every division takes an idle cycle plus DIVLEN+1 cycles, padded
  localparam int watchdogNs = (tableLen + randCount + 1) * (`DIVLEN + 4) * 8 + 16 * 8 + 64;

  // Operand values as fractions in [1,2)
  localparam operand_t opMsb     = {1'b1, {(`DIVLEN-1){1'b0}}};
  localparam operand_t opOnes    = '1;
  localparam operand_t opThreeH  = {2'b11, {(`DIVLEN-2){1'b0}}};
  localparam operand_t opNineE   = {4'b1001, {(`DIVLEN-4){1'b0}}};
  localparam operand_t opTopBits = {3'b111, {(`DIVLEN-3){1'b0}}};

  logic     clk;
  logic     arstN;
  logic     start;
  operand_t dividend;
  operand_t divisor;
  logic     busy;
  logic     done;
  quot_t    quotient;
  logic     inexact;

  vector_t     directed [tableLen];
  quot_t       lastQuot;
  logic        lastInexact;
  logic [31:0] rndState;
  int          negDigits;
  int          corrections;
  int          exactCount;
  int          inexactCount;

  srtDivider i_dut (
    .clk(clk), .arstN(arstN), .start(start), .dividend(dividend), .divisor(divisor),
    .busy(busy), .done(done), .quotient(quotient), .inexact(inexact)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkQuot(input string name, input quot_t actual, input quot_t expected);
    if (actual !== expected) begin
      reportFailure($sformatf("Fail at %0d ns: %s = %h, expected %h",
                              $time, name, actual, expected));
    end
  endtask

  task automatic checkBit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      reportFailure($sformatf("Fail at %0d ns: %s = %b, expected %b",
                              $time, name, actual, expected));
    end
  endtask

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Model: floor(X * 2^(DIVLEN-1) / D), inexact on a nonzero remainder
  task automatic referenceDivide(input operand_t x, input operand_t d,
                                 output quot_t q, output logic inex);
    logic [2*`DIVLEN-1:0] num;
    logic [2*`DIVLEN-1:0] den;
    logic [2*`DIVLEN-1:0] quo;
    num  = {1'b0, x, {(`DIVLEN-1){1'b0}}};
    den  = {{`DIVLEN{1'b0}}, d};
    quo  = num / den;
    q    = quo[`DIVLEN-1:0];
    inex = ((num % den) != '0);
  endtask

  // Hand-derived expectations from the floor rule
  task automatic loadTable();
    directed[0] = '{opMsb, opMsb, opMsb, 1'b0};
    directed[1] = '{opOnes, opOnes, opMsb, 1'b0};
    directed[2] = '{opOnes, opMsb, opOnes, 1'b0};
    // 2^(2N-2) / (2^N-1) leaves 2^(N-2) over
    directed[3] = '{opMsb, opOnes, {2'b01, {(`DIVLEN-2){1'b0}}}, 1'b1};
    directed[4] = '{opThreeH, opMsb, opThreeH, 1'b0};
    // One over 1.5 gives the 0101 pattern, N even
    directed[5] = '{opMsb, opThreeH, {(`DIVLEN/2){2'b01}}, 1'b1};
    directed[6] = '{opNineE, opThreeH, {3'b011, {(`DIVLEN-3){1'b0}}}, 1'b0};
    directed[7] = '{opOnes, opThreeH, {(`DIVLEN/2){2'b10}}, 1'b0};
  endtask

  ////////////////////////////////////////
  // One division, start to done
  ////////////////////////////////////////
  task automatic runDivision(input operand_t x, input operand_t d, input quot_t expQ,
                             input logic expI, input bit midStart);
    int   cycles;
    logic doneSeen;
    @(posedge clk);
    #1;
    // Idle cycle, previous result still held
    checkBit("busy", busy, 1'b0);
    checkBit("done", done, 1'b0);
    checkQuot("quotient", quotient, lastQuot);
    checkBit("inexact", inexact, lastInexact);
    start    = 1'b1;
    dividend = x;
    divisor  = d;
    cycles   = 0;
    doneSeen = 1'b0;
    while (!doneSeen && cycles < `DIVLEN + 4) begin
      @(posedge clk);
      #1;
      cycles++;
      checkBit("busy", busy, 1'b1);
      doneSeen = done;
      start    = 1'b0;
      // Start mid-operation with other operands, must be dropped
      if (midStart && cycles == `DIVLEN / 2) begin
        start    = 1'b1;
        dividend = opOnes;
        divisor  = opMsb;
      end
    end
    start = 1'b0;
    if (!doneSeen) begin
      reportFailure($sformatf("done did not arrive within %0d cycles of start",
                              `DIVLEN + 4));
    end
    if (cycles != `DIVLEN + 1) begin
      reportFailure($sformatf("done came %0d cycles after start instead of %0d",
                              cycles, `DIVLEN + 1));
    end
    checkQuot("quotient", quotient, expQ);
    checkBit("inexact", inexact, expI);
    lastQuot    = expQ;
    lastInexact = expI;
  endtask

  // Datapath events the random run has to reach
  always @(posedge clk) begin
    if (i_dut.iterEn && !i_dut.qp && !i_dut.qz) begin
      negDigits++;
    end
    if (i_dut.finish && i_dut.resNeg) begin
      corrections++;
    end
  end

  initial begin
    #(watchdogNs);
    reportFailure("Watchdog expired before the test sequence completed");
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    quot_t    expQ;
    logic     expI;
    operand_t x;
    operand_t d;
    arstN        = 1'b0;
    start        = 1'b0;
    dividend     = '0;
    divisor      = '0;
    rndState     = 32'h7b9f;
    lastQuot     = '0;
    lastInexact  = 1'b0;
    negDigits    = 0;
    corrections  = 0;
    exactCount   = 0;
    inexactCount = 0;
    loadTable();
    repeat (16) @(posedge clk);
    #1;
    arstN = 1'b1;
    // Outputs cleared by reset
    checkBit("busy", busy, 1'b0);
    checkBit("done", done, 1'b0);
    checkQuot("quotient", quotient, '0);
    checkBit("inexact", inexact, 1'b0);

    for (int i = 0; i < tableLen; i++) begin
      runDivision(directed[i].dividend, directed[i].divisor, directed[i].quot,
                  directed[i].inexact, 1'b0);
    end
    // Same case again with a dropped start in the middle
    runDivision(directed[3].dividend, directed[3].divisor, directed[3].quot,
                directed[3].inexact, 1'b1);

    // Back to back random divisions, MSB forced for normalized operands
    for (int i = 0; i < randCount; i++) begin
      rndState = nextRandom(rndState);
      x        = operand_t'(rndState) | opMsb;
      rndState = nextRandom(rndState);
      d        = operand_t'(rndState) | opMsb;
      // Every fourth divisor keeps three bits so some quotients come out exact
      if (i % 4 == 3) begin
        d = d & opTopBits;
      end
      referenceDivide(x, d, expQ, expI);
      if (expI) begin
        inexactCount++;
      end else begin
        exactCount++;
      end
      runDivision(x, d, expQ, expI, 1'b0);
    end

    if (negDigits == 0 || corrections == 0 || exactCount == 0 || inexactCount == 0) begin
      reportFailure($sformatf(
        "Random run missed a case: -1 digits %0d, QM picks %0d, exact %0d, inexact %0d",
        negDigits, corrections, exactCount, inexactCount));
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// File: hw/srtDivider.sv
////////////////////////////////////////
// done comes DIVLEN+1 cycles after start
////////////////////////////////////////
`timescale 1ns/1ps

module srtDivider (
  input  logic                clk,
  input  logic                arstN,
  input  logic                start,
  input  srtDivPkg::operand_t dividend,
  input  srtDivPkg::operand_t divisor,
  output logic                busy,
  output logic                done,
  output srtDivPkg::quot_t    quotient,
  output logic                inexact
);

  logic       load, iterEn, finish, lastIter;
  logic       qp, qz;
  logic       resNeg, resZero;
  logic [3:0] wsMsbs, wcMsbs;
  logic       inexactReg;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////
  srtDivCtrl ctrl (
    .clk(clk), .arstN(arstN), .start(start), .lastIter(lastIter),
    .load(load), .iterEn(iterEn), .finish(finish), .busy(busy), .done(done)
  );

  srtIterCounter counter (
    .clk(clk), .arstN(arstN), .load(load), .iterEn(iterEn), .lastIter(lastIter)
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////
  srtResidual residual (
    .clk(clk), .arstN(arstN), .load(load), .iterEn(iterEn), .qp(qp), .qz(qz),
    .dividend(dividend), .divisor(divisor), .wsMsbs(wsMsbs), .wcMsbs(wcMsbs),
    .resNeg(resNeg), .resZero(resZero)
  );

  srtQuotSel quotSel (.wsMsbs(wsMsbs), .wcMsbs(wcMsbs), .qp(qp), .qz(qz));

  srtOtfConvert otf (
    .clk(clk), .arstN(arstN), .load(load), .iterEn(iterEn), .finish(finish),
    .qp(qp), .qz(qz), .resNeg(resNeg), .quotient(quotient)
  );

  // Sticky flag, nonzero remainder
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      inexactReg <= 1'b0;
    end else if (finish) begin
      inexactReg <= ~resZero;
    end
  end

  // Bypass so the flag lines up with done
  assign inexact = finish ? ~resZero : inexactReg;

endmodule

// File: hw/srtDatapath/srtOtfConvert.sv
////////////////////////////////////////
// Quotient output holds until next finish
////////////////////////////////////////
`timescale 1ns/1ps
`include "srtDivDefines.svh"

module srtOtfConvert (
  input  logic             clk,
  input  logic             arstN,
  input  logic             load,
  input  logic             iterEn,
  input  logic             finish,
  input  logic             qp,
  input  logic             qz,
  input  logic             resNeg,
  output srtDivPkg::quot_t quotient
);
  import srtDivPkg::*;

  // QM tracks Q minus one unit in the current last place
  quot_t q, qm;
  quot_t qNext, qmNext;
  quot_t quotFinal, quotReg;

  // Append rules, no carry propagation
  always_comb begin
    if (qp) begin
      qNext  = {q[`DIVLEN-2:0], 1'b1};
      qmNext = {q[`DIVLEN-2:0], 1'b0};
    end else if (qz) begin
      qNext  = {q[`DIVLEN-2:0], 1'b0};
      qmNext = {qm[`DIVLEN-2:0], 1'b1};
    end else begin
      // Digit -1
      qNext  = {qm[`DIVLEN-2:0], 1'b1};
      qmNext = {qm[`DIVLEN-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////
  // Q and QM registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      q  <= '0;
      qm <= '1;
    end else if (load) begin
      // Q = 0 and QM = -1 before the first digit
      q  <= '0;
      qm <= '1;
    end else if (iterEn) begin
      q  <= qNext;
      qm <= qmNext;
    end
  end

  // Negative remainder means Q is one unit high
  assign quotFinal = resNeg ? qm : q;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      quotReg <= '0;
    end else if (finish) begin
      quotReg <= quotFinal;
    end
  end

  // Result visible already in the done cycle
  assign quotient = finish ? quotFinal : quotReg;

  // Selection never asks for +1 and 0 at once
  digitOneHot: assert property (@(posedge clk) disable iff (!arstN) !(qp && qz));

endmodule

// File: hw/srtDatapath/srtResidual.sv
////////////////////////////////////////
// Needs |W| <= D, so W0 = X/2 on load
////////////////////////////////////////
`timescale 1ns/1ps
`include "srtDivDefines.svh"

module srtResidual (
  input  logic                clk,
  input  logic                arstN,
  input  logic                load,
  input  logic                iterEn,
  input  logic                qp,
  input  logic                qz,
  input  srtDivPkg::operand_t dividend,
  input  srtDivPkg::operand_t divisor,
  output logic [3:0]          wsMsbs,
  output logic [3:0]          wcMsbs,
  output logic                resNeg,
  output logic                resZero
);
  import srtDivPkg::*;

  residual_t ws, wc, d;
  residual_t ws2, wc2, f, maj;
  residual_t wSum, wRem;

  // Shifted residual words, top bits feed digit selection
  assign ws2    = {ws[`RESLEN-2:0], 1'b0};
  assign wc2    = {wc[`RESLEN-2:0], 1'b0};
  assign wsMsbs = ws2[`RESLEN-1 -: 4];
  assign wcMsbs = wc2[`RESLEN-1 -: 4];

  // -qD term: +1 adds ~D plus carry-in, -1 adds D
  always_comb begin
    if (qp) begin
      f = ~d;
    end else if (qz) begin
      f = '0;
    end else begin
      f = d;
    end
  end

  // 3:2 compressor carries
  assign maj = (ws2 & wc2) | (ws2 & f) | (wc2 & f);

  ////////////////////////////////////////
  // Residual and divisor registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ws <= '0;
      wc <= '0;
      d  <= '0;
    end else if (load) begin
      // Dividend LSB lands in the extra fraction bit
      ws <= {4'b0000, dividend};
      wc <= '0;
      d  <= {3'b000, divisor, 1'b0};
    end else if (iterEn) begin
      ws <= ws2 ^ wc2 ^ f;
      // Carry-in completes the two's complement of D
      wc <= {maj[`RESLEN-2:0], qp};
    end
  end

  ////////////////////////////////////////
  // Final resolution
  ////////////////////////////////////////
  assign wSum   = ws + wc;
  assign resNeg = wSum[`RESLEN-1];
  // Negative residual gets D added back, W = -D is an exact result
  assign wRem    = resNeg ? wSum + d : wSum;
  assign resZero = (wRem == '0);

endmodule

// File: hw/srtDatapath/srtQuotSel.sv
////////////////////////////////////////
// Inputs are the top 4 bits of 2WS, 2WC
////////////////////////////////////////
`timescale 1ns/1ps

module srtQuotSel (
  input  logic [3:0] wsMsbs,
  input  logic [3:0] wcMsbs,
  output logic       qp,
  output logic       qz
);

  logic [3:0] p;
  logic [2:0] g;
  logic       magnitude;
  logic       sign;
  logic       cout;

  // Half-adder terms over the estimate bits
  assign p = wsMsbs ^ wcMsbs;
  assign g = wsMsbs[2:0] & wcMsbs[2:0];

  // Lower three bits summing to 111 means estimate is -1
  // since |2W| stays below 4
  assign magnitude = ~(&p[2:0]);

  // Carry into the sign position
  assign cout = g[2] | (p[2] & (g[1] | (p[1] & g[0])));
  assign sign = p[3] ^ cout;

  ////////////////////////////////////////
  // Digit select
  ////////////////////////////////////////
  // Estimate >= 0 gives +1, -1 gives 0, <= -2 gives -1
  assign qp = magnitude & ~sign;
  assign qz = ~magnitude;
  // Both low encodes digit -1

endmodule

// File: hw/srtIterCounter.sv
////////////////////////////////////////
// Counts DIVLEN iterations per load
////////////////////////////////////////
`timescale 1ns/1ps
`include "srtDivDefines.svh"

module srtIterCounter (
  input  logic clk,
  input  logic arstN,
  input  logic load,
  input  logic iterEn,
  output logic lastIter
);
  import srtDivPkg::*;

  // First ITER cycle sees DIVLEN-1, last one sees zero
  localparam count_t startCount = count_t'(`DIVLEN - 1);

  count_t count;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      count <= '0;
    end else if (load) begin
      count <= startCount;
    end else if (iterEn) begin
      count <= count - 1'b1;
    end
  end

  // Flag the final digit cycle
  assign lastIter = iterEn && (count == '0);

  // Controller has to leave ITER before the count wraps
  noWrapWhileIter: assert property (
    @(posedge clk) disable iff (!arstN) iterEn |-> (count <= startCount)
  );

endmodule

// File: hw/srtDivCtrl.sv
////////////////////////////////////////
// Start while busy is dropped
////////////////////////////////////////
`timescale 1ns/1ps

module srtDivCtrl (
  input  logic clk,
  input  logic arstN,
  input  logic start,
  input  logic lastIter,
  output logic load,
  output logic iterEn,
  output logic finish,
  output logic busy,
  output logic done
);
  import srtDivPkg::*;

  divState_t state;
  divState_t stateNext;

  ////////////////////////////////////////
  // State register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  // Next state
  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (start) begin
          stateNext = ITER;
        end
      end
      // One digit per cycle until the counter runs out
      ITER: begin
        if (lastIter) begin
          stateNext = FINISH;
        end
      end
      FINISH: stateNext = IDLE;
      default: stateNext = IDLE;
    endcase
  end

  ////////////////////////////////////////
  // Outputs, decoded from state
  ////////////////////////////////////////
  // Load only when idle, so a start mid-operation is lost
  assign load   = (state == IDLE) && start;
  assign iterEn = (state == ITER);
  assign finish = (state == FINISH);
  assign busy   = iterEn || finish;
  // Result is resolved in FINISH
  assign done   = finish;

  // Counter must only flag its last count while iterating
  lastIterOnlyInIter: assert property (
    @(posedge clk) disable iff (!arstN) lastIter |-> (state == ITER)
  );

endmodule

// File: common/srtDivPkg.sv
////////////////////////////////////////
// Widths follow the defines header
////////////////////////////////////////
`include "srtDivDefines.svh"

package srtDivPkg;

  // Dividend and divisor, fraction in [1,2) with MSB as units bit
  typedef logic [`DIVLEN-1:0] operand_t;

  // Quotient word, DIVLEN-1 fraction bits
  typedef logic [`DIVLEN-1:0] quot_t;

  // Carry-save residual field, two's complement
  // Bit k carries weight 2^(k-DIVLEN)
  typedef logic [`RESLEN-1:0] residual_t;

  // Remaining iteration count
  typedef logic [`CNTW-1:0] count_t;

  // Controller states
  typedef enum logic [1:0] {
    IDLE,
    ITER,
    FINISH
  } divState_t;

endpackage

// File: common/srtDivDefines.svh
////////////////////////////////////////
// DIVLEN must be even and at least 8
// Operands are normalized, MSB set
////////////////////////////////////////
`ifndef SRT_DIV_DEFINES_SVH
`define SRT_DIV_DEFINES_SVH

// Operand and quotient width, also the number of iteration cycles
`define DIVLEN 16

// Residual width
// sign, two guard bits, units bit, DIVLEN-1 fraction bits, one extra bit
`define RESLEN (`DIVLEN + 4)

// Iteration counter width, one spare bit above the count range
`define CNTW ($clog2(`DIVLEN) + 1)

`endif
